// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= computer_tb
FILELIST    ?= computer.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --assert -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing --assert
PASS_TEXT   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== computer.f ====
verilog/cpu_isa_pkg.sv
verilog/cpu_mem_pkg.sv
verilog/stream_fifo.sv
verilog/alu.sv
verilog/main_memory.sv
verilog/program_loader.sv
verilog/control_unit.sv
verilog/computer.sv
dv/computer_tb.sv

// ==== dv/computer_tb.sv ====
`timescale 1ns/1ns

module computer_tb
    import cpu_mem_pkg::*;
();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int load_timeout = 100;
    localparam int run_timeout  = 5000;
    localparam int watchdog_ns  = 400000;
    localparam int seed         = 48103;

    // keywords of the test file
    localparam logic [255:0] kw_comment = 256'("#");
    localparam logic [255:0] kw_test    = 256'("test");
    localparam logic [255:0] kw_load    = 256'("load");
    localparam logic [255:0] kw_last    = 256'("last");
    localparam logic [255:0] kw_expect  = 256'("expect");
    localparam logic [255:0] kw_end     = 256'("end");

    logic       clk;
    logic       reset;
    logic       load_valid;
    logic       load_ready;
    load_word_t load_word;
    logic       out_valid;
    logic       out_ready;
    word_t      out_data;
    logic       halted;

    int   fd;
    int   tests_run;
    int   mismatches;
    int   failures;
    logic aborted;

    // block currently read from the file
    logic [255:0] test_name;
    int unsigned  ready_pct;
    addr_t        load_addr[$];
    word_t        load_data[$];
    logic         load_last[$];
    word_t        expected[$];
    word_t        received[$];

    computer dut_i (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_word  (load_word),
        .out_ready  (out_ready),
        .load_ready (load_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic check(input int index, input word_t want, input word_t got);
        if (got !== want) begin
            $display("Fail %0s output %0d: expected %h, got %h", test_name, index, want, got);
            mismatches++;
        end
    endtask

    // hex digits only, padding bytes skipped
    function automatic logic parse_hex(input logic [255:0] tok, output word_t value);
        logic [7:0] c;
        logic       ok;
        value = '0;
        ok    = (tok != '0);
        for (int i = 31; i >= 0; i--) begin
            c = tok[i*8 +: 8];
            if (c >= "0" && c <= "9") begin
                value = {value[11:0], c[3:0]};
            end else if ((c >= "a" && c <= "f") || (c >= "A" && c <= "F")) begin
                value = {value[11:0], c[3:0] + 4'd9};
            end else if (c != 8'h00) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // one block: test line, load lines, expect line, end line
    task automatic read_block(output logic found);
        logic [255:0]  tok;
        logic [1023:0] line;
        word_t         value;
        addr_t         next_addr;
        int            code;
        int            mode;
        logic          closed;
        logic          done;
        found     = 1'b0;
        done      = 1'b0;
        closed    = 1'b0;
        mode      = 0;
        next_addr = '0;
        load_addr.delete();
        load_data.delete();
        load_last.delete();
        expected.delete();
        while (!done) begin
            tok  = '0;
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                if (found) begin
                    $display("test %0s has no end line", test_name);
                    failures++;
                end
                done = 1'b1;
            end else if (tok == kw_comment) begin
                code = $fgets(line, fd);
            end else if (tok == kw_test) begin
                code  = $fscanf(fd, "%s %d", test_name, ready_pct);
                found = 1'b1;
            end else if (tok == kw_load || tok == kw_last) begin
                code   = $fscanf(fd, "%h", next_addr);
                closed = (tok == kw_last);
                mode   = 1;
            end else if (tok == kw_expect) begin
                mode = 2;
            end else if (tok == kw_end) begin
                // final word of the last line carries the flag
                if (closed && load_last.size() > 0) begin
                    load_last[load_last.size() - 1] = 1'b1;
                end else begin
                    $display("test %0s has no last line", test_name);
                    failures++;
                end
                done = 1'b1;
            end else if (mode != 0 && parse_hex(tok, value)) begin
                if (mode == 1) begin
                    load_addr.push_back(next_addr);
                    load_data.push_back(value);
                    load_last.push_back(1'b0);
                    next_addr = next_addr + 1'b1;
                end else begin
                    expected.push_back(value);
                end
            end else begin
                $display("unexpected token %0s in the test file", tok);
                failures++;
                found = 1'b0;
                done  = 1'b1;
            end
        end
    endtask

    task automatic apply_reset();
        reset      = 1'b1;
        load_valid = 1'b0;
        out_ready  = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        if (out_valid !== 1'b0 || halted !== 1'b0 || load_ready !== 1'b1) begin
            $display("%0s: ports not idle after reset", test_name);
            failures++;
        end
    endtask

    // word stays on the port until the buffer takes it
    task automatic send_word(input addr_t addr, input word_t data, input logic last);
        int waited;
        waited         = 0;
        load_word.addr = addr;
        load_word.data = data;
        load_word.last = last;
        load_valid     = 1'b1;
        // ready seen at a falling edge, transfer on the next rising edge
        while (!load_ready && !aborted) begin
            @(negedge clk);
            waited++;
            if (waited > load_timeout) begin
                $display("%0s: load port never became ready", test_name);
                failures++;
                aborted = 1'b1;
            end
        end
        @(negedge clk);
        load_valid = 1'b0;
    endtask

    // random back-pressure until halted with the output buffer drained
    task automatic collect_outputs();
        int waited;
        waited = 0;
        while (!aborted && !(halted && !out_valid)) begin
            out_ready = (($urandom % 100) < ready_pct);
            if (out_valid && out_ready) begin
                received.push_back(out_data);
            end
            @(negedge clk);
            waited++;
            if (waited > run_timeout) begin
                $display("%0s: program never halted", test_name);
                failures++;
                aborted = 1'b1;
            end
        end
        out_ready = 1'b0;
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < expected.size() && i < received.size(); i++) begin
            check(i, expected[i], received[i]);
        end
        if (received.size() > expected.size()) begin
            $display("%0s: %0d extra outputs, first extra %h", test_name,
                     received.size() - expected.size(), received[expected.size()]);
            failures++;
        end else if (received.size() < expected.size()) begin
            $display("%0s: %0d outputs missing, next expected %h", test_name,
                     expected.size() - received.size(), expected[received.size()]);
            failures++;
        end
    endtask

    task automatic run_test();
        aborted = 1'b0;
        received.delete();
        apply_reset();
        for (int i = 0; i < load_data.size() && !aborted; i++) begin
            send_word(load_addr[i], load_data[i], load_last[i]);
        end
        collect_outputs();
        if (!aborted) begin
            compare_outputs();
        end
        tests_run++;
    endtask

    task automatic report_counts();
        $display("tests run %0d, value mismatches %0d, other failures %0d",
                 tests_run, mismatches, failures);
    endtask

    initial begin
        logic found;
        reset      = 1'b1;
        load_valid = 1'b0;
        load_word  = '0;
        out_ready  = 1'b0;
        tests_run  = 0;
        mismatches = 0;
        failures   = 0;
        test_name  = '0;
        void'($urandom(seed));
        @(negedge clk);
        fd = $fopen("dv/computer_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/computer_tests.txt");
            failures++;
        end else begin
            found = 1'b1;
            while (found) begin
                read_block(found);
                if (found) begin
                    run_test();
                end
            end
            $fclose(fd);
        end
        if (tests_run == 0) begin
            $display("no test block was run");
            failures++;
        end
        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // hard limit on the whole run
    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t, run stopped", $time);
        report_counts();
        $display("test failed");
        $finish;
    end

endmodule

// ==== dv/computer_tests.txt ====
# blocks: test <name> <out_ready percent>, load or last <hex start address> <hex words>,
# expect <hex outputs in order>, end; the final word of the last line closes the image
test ldi_out 50
last 000 1005 7000 1abc 7000 1fff 7000 0000
expect 0005 0abc 0fff
end
test alu_arith 70
load 020 1234 0f0f 0010 0007 0000 0001
last 000 2020 4021 7000 4121 7000 4222 7000 4323 7000 4324 7000 4125 7000 0000
expect 2143 1234 2340 0509 ffff fffe
end
test shift_logic 30
load 030 8001 f0f0 ff00 0000
load 000 2030 4430 7000 2030 4530 7000 2030 4630 7000 4730 7000 2031 4832 7000 4932 7000
last 010 4a31 7000 4b32 7000 4c31 7000 4d31 7000 4e32 7000 4f33 7000 4e33 7000 4f32 7000 0000
expect 0002 4000 0003 8001 f000 ff00 0ff0 000f ffff f0f0 0000 0001 0001 0000
end
test countdown 60
load 041 0001
last 000 1003 3800 2800 6009 7000 4141 3800 5002 0000 7000 0000
expect 0003 0002 0001 0000
end
test backpressure 5
load 050 0000
load 000 1001 7000 4650 7000 4650 7000 4650 7000 4650 7000 4650 7000 4650 7000 4650 7000
last 010 4650 7000 4650 7000 0000
expect 0001 0002 0004 0008 0010 0020 0040 0080 0100 0200
end
test reload 50
last 000 1123 7000 0000
expect 0123
end

// ==== verilog/alu.sv ====
`timescale 1ns/1ns

module alu
    import cpu_isa_pkg::*, cpu_mem_pkg::*;
(
    input  alu_func_t func,
    input  word_t     operand_a,
    input  word_t     operand_b,
    output word_t     result
);

    always_comb begin
        case (func)
            // arithmetic, truncated to the word
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_MUL:  result = operand_a * operand_b;
            // divide by zero saturates to all ones
            ALU_DIV: begin
                if (operand_b == '0) begin
                    result = '1;
                end else begin
                    result = operand_a / operand_b;
                end
            end
            // single-bit shifts and rotates on a only
            ALU_SHL:  result = operand_a << 1;
            ALU_SHR:  result = operand_a >> 1;
            ALU_ROL:  result = {operand_a[word_bits-2:0], operand_a[word_bits-1]};
            ALU_ROR:  result = {operand_a[0], operand_a[word_bits-1:1]};
            // bitwise
            ALU_AND:  result = operand_a & operand_b;
            ALU_OR:   result = operand_a | operand_b;
            ALU_XOR:  result = operand_a ^ operand_b;
            ALU_NOR:  result = ~(operand_a | operand_b);
            ALU_NAND: result = ~(operand_a & operand_b);
            ALU_XNOR: result = ~(operand_a ^ operand_b);
            // compares, unsigned, give 1 or 0
            ALU_GT: begin
                result = (operand_a > operand_b) ? word_t'(1) : word_t'(0);
            end
            ALU_EQ: begin
                result = (operand_a == operand_b) ? word_t'(1) : word_t'(0);
            end
            default:  result = '0;
        endcase
    end

    // known inputs must never leave an X in the result
    always_comb begin
        if (!$isunknown({func, operand_a, operand_b})) begin
            a_result_known: assert (!$isunknown(result));
        end
    end

endmodule

// ==== verilog/computer.sv ====
`timescale 1ns/1ns

module computer
    import cpu_isa_pkg::*, cpu_mem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load_valid,
    input  load_word_t load_word,
    input  logic       out_ready,
    output logic       load_ready,
    output logic       out_valid,
    output word_t      out_data,
    output logic       halted
);

    // load stream after buffering
    logic       ld_valid;
    logic       ld_ready;
    load_word_t ld_word;

    // memory side
    mem_req_t load_req;
    logic     load_req_valid;
    mem_req_t cpu_req;
    logic     cpu_req_valid;
    word_t    rdata;
    logic     run;

    // alu side
    alu_func_t alu_func;
    word_t     operand_a;
    word_t     operand_b;
    word_t     alu_result;

    // results on their way to the output fifo
    logic  res_valid;
    logic  res_ready;
    word_t res_data;

    stream_fifo #(
        .T(load_word_t)
    ) load_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (load_valid),
        .in_data   (load_word),
        .out_ready (ld_ready),
        .in_ready  (load_ready),
        .out_valid (ld_valid),
        .out_data  (ld_word)
    );

    program_loader program_loader_i (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (ld_valid),
        .in_data        (ld_word),
        .in_ready       (ld_ready),
        .load_req       (load_req),
        .load_req_valid (load_req_valid),
        .run            (run)
    );

    main_memory main_memory_i (
        .clk            (clk),
        .load_req       (load_req),
        .load_req_valid (load_req_valid),
        .cpu_req        (cpu_req),
        .cpu_req_valid  (cpu_req_valid),
        .rdata          (rdata)
    );

    alu alu_i (
        .func      (alu_func),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .result    (alu_result)
    );

    control_unit control_unit_i (
        .clk           (clk),
        .reset         (reset),
        .run           (run),
        .rdata         (rdata),
        .alu_result    (alu_result),
        .out_ready     (res_ready),
        .cpu_req       (cpu_req),
        .cpu_req_valid (cpu_req_valid),
        .alu_func      (alu_func),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .out_valid     (res_valid),
        .out_data      (res_data),
        .halted        (halted)
    );

    stream_fifo #(
        .T(word_t)
    ) out_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (res_valid),
        .in_data   (res_data),
        .out_ready (out_ready),
        .in_ready  (res_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== verilog/control_unit.sv ====
`timescale 1ns/1ns

module control_unit
    import cpu_isa_pkg::*, cpu_mem_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    input  word_t     rdata,
    input  word_t     alu_result,
    input  logic      out_ready,
    output mem_req_t  cpu_req,
    output logic      cpu_req_valid,
    output alu_func_t alu_func,
    output word_t     operand_a,
    output word_t     operand_b,
    output logic      out_valid,
    output word_t     out_data,
    output logic      halted
);

    cpu_state_t state;

    // architectural registers
    addr_t  pc;
    addr_t  mar;
    word_t  mbr;
    instr_t ir;
    word_t  acc;

    // decode of the word arriving from memory
    instr_t     fetched;
    alu_field_t fetched_alu;
    alu_field_t ir_alu;
    addr_t      operand_addr;

    assign fetched     = instr_t'(rdata);
    assign fetched_alu = alu_field_t'(fetched.field);
    assign ir_alu      = alu_field_t'(ir.field);

    // ALU operands live in page 0, the rest use the full field
    assign operand_addr = (fetched.opcode == OP_ALU) ? addr_t'(fetched_alu.page0_addr)
                                                      : fetched.field;

    assign alu_func  = ir_alu.func;
    assign operand_a = acc;
    assign operand_b = mbr;

    assign out_valid = (state == OUTPUT);
    assign out_data  = acc;
    assign halted    = (state == HALTED);

    // memory requests, fetch from pc, operands from mar
    always_comb begin
        cpu_req.addr  = mar;
        cpu_req.wdata = acc;
        cpu_req.we    = 1'b0;
        cpu_req_valid = 1'b0;
        case (state)
            FETCH: begin
                cpu_req.addr  = pc;
                cpu_req_valid = run;
            end
            DECODE: begin
                case (ir.opcode)
                    OP_LDA, OP_ALU: cpu_req_valid = 1'b1;
                    OP_STA: begin
                        cpu_req.we    = 1'b1;
                        cpu_req_valid = 1'b1;
                    end
                    default: cpu_req_valid = 1'b0;
                endcase
            end
            default: cpu_req_valid = 1'b0;
        endcase
    end

    // state and pc
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= '0;
        end else begin
            case (state)
                // idle here until the loader hands over
                FETCH: begin
                    if (run) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    // wraps 4095 to 0
                    pc    <= pc + 1'b1;
                    state <= DECODE;
                end
                DECODE: begin
                    case (ir.opcode)
                        OP_LDI, OP_STA, OP_JMP, OP_JZ: state <= EXECUTE;
                        OP_LDA, OP_ALU: state <= OPERAND_WAIT;
                        OP_OUT: state <= OUTPUT;
                        // halt and unused codes
                        default: state <= HALTED;
                    endcase
                end
                OPERAND_WAIT: state <= EXECUTE;
                EXECUTE: begin
                    if (ir.opcode == OP_JMP || (ir.opcode == OP_JZ && acc == '0)) begin
                        pc <= mar;
                    end
                    state <= FETCH;
                end
                // back-pressure point, hold until the fifo takes acc
                OUTPUT: begin
                    if (out_ready) begin
                        state <= FETCH;
                    end
                end
                default: state <= HALTED;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        case (state)
            FETCH_WAIT: begin
                ir  <= fetched;
                mbr <= rdata;
                mar <= operand_addr;
            end
            OPERAND_WAIT: mbr <= rdata;
            EXECUTE: begin
                case (ir.opcode)
                    // zero-extended immediate
                    OP_LDI: acc <= word_t'(ir.field);
                    OP_LDA: acc <= mbr;
                    OP_ALU: acc <= alu_result;
                    default: acc <= acc;
                endcase
            end
            default: acc <= acc;
        endcase
    end

    // stalled output keeps its value
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // memory untouched by the cpu while loading
    a_no_req_before_run: assert property (@(posedge clk) disable iff (reset)
        !run |-> !cpu_req_valid);

endmodule

// ==== verilog/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // operand field below the opcode nibble
    localparam int field_bits = 12;
    // ALU instructions only reach page 0
    localparam int page_bits = 8;

    // instruction class in the top nibble
    // codes 8 to 15 decode as halt
    typedef enum logic [3:0] {
        OP_HALT = 4'd0,
        OP_LDI  = 4'd1,
        OP_LDA  = 4'd2,
        OP_STA  = 4'd3,
        OP_ALU  = 4'd4,
        OP_JMP  = 4'd5,
        OP_JZ   = 4'd6,
        OP_OUT  = 4'd7
    } opcode_t;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_MUL  = 4'd2,
        ALU_DIV  = 4'd3,
        ALU_SHL  = 4'd4,
        ALU_SHR  = 4'd5,
        ALU_ROL  = 4'd6,
        ALU_ROR  = 4'd7,
        ALU_AND  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_XOR  = 4'd10,
        ALU_NOR  = 4'd11,
        ALU_NAND = 4'd12,
        ALU_XNOR = 4'd13,
        ALU_GT   = 4'd14,
        ALU_EQ   = 4'd15
    } alu_func_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [field_bits-1:0]  field;
    } instr_t;

    // field layout for ALU instructions
    typedef struct packed {
        alu_func_t              func;
        logic [page_bits-1:0]   page0_addr;
    } alu_field_t;

    typedef enum logic [2:0] {
        FETCH,
        FETCH_WAIT,
        DECODE,
        OPERAND_WAIT,
        EXECUTE,
        OUTPUT,
        HALTED
    } cpu_state_t;

endpackage

// ==== verilog/cpu_mem_pkg.sv ====
package cpu_mem_pkg;

    localparam int addr_bits = 12;
    localparam int word_bits = 16;
    localparam int mem_words = 4096;
    // wide enough to count a full memory image
    localparam int mem_count_bits = addr_bits + 1;

    // stream buffers, depth kept a power of two
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_bits = $clog2(fifo_depth);
    localparam int fifo_cnt_bits = fifo_ptr_bits + 1;

    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [word_bits-1:0] word_t;

    // one word of the program image
    typedef struct packed {
        addr_t  addr;
        word_t  data;
        logic   last;
    } load_word_t;

    // read when valid and we is low
    typedef struct packed {
        addr_t  addr;
        word_t  wdata;
        logic   we;
    } mem_req_t;

endpackage

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ns

module main_memory
    import cpu_mem_pkg::*;
(
    input  logic     clk,
    input  mem_req_t load_req,
    input  logic     load_req_valid,
    input  mem_req_t cpu_req,
    input  logic     cpu_req_valid,
    output word_t    rdata
);

    // 4096 words, the reach of a 12-bit address
    word_t mem [mem_words];

    always_ff @(posedge clk) begin
        // loader has priority, always a write
        if (load_req_valid) begin
            mem[load_req.addr] <= load_req.wdata;
        end else if (cpu_req_valid) begin
            if (cpu_req.we) begin
                mem[cpu_req.addr] <= cpu_req.wdata;
            end else begin
                // read data lands one cycle later
                rdata <= mem[cpu_req.addr];
            end
        end
    end

    // loader finishes before the cpu may start
    a_one_master: assert property (@(posedge clk)
        !(load_req_valid === 1'b1 && cpu_req_valid === 1'b1));

endmodule

// ==== verilog/program_loader.sv ====
`timescale 1ns/1ns

module program_loader
    import cpu_mem_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  load_word_t in_data,
    output logic       in_ready,
    output mem_req_t   load_req,
    output logic       load_req_valid,
    output logic       run
);

    logic [mem_count_bits-1:0] word_count;

    // stop taking words once the image is complete
    assign in_ready       = !run;
    assign load_req_valid = in_valid && in_ready;

    // each accepted word goes straight to memory
    assign load_req.addr  = in_data.addr;
    assign load_req.wdata = in_data.data;
    assign load_req.we    = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            run        <= 1'b0;
            word_count <= '0;
        end else if (load_req_valid) begin
            word_count <= word_count + 1'b1;
            // run goes high the cycle after the last write
            if (in_data.last) begin
                run <= 1'b1;
            end
        end
    end

    // image never holds more words than memory
    a_image_fits: assert property (@(posedge clk) disable iff (reset)
        load_req_valid |-> word_count < mem_count_bits'(mem_words));

endmodule

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/1ns

module stream_fifo
    import cpu_mem_pkg::*;
#(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  T     in_data,
    input  logic out_ready,
    output logic in_ready,
    output logic out_valid,
    output T     out_data
);

    // storage, no reset needed
    T mem [fifo_depth];

    logic [fifo_ptr_bits-1:0] wr_ptr;
    logic [fifo_ptr_bits-1:0] rd_ptr;
    logic [fifo_cnt_bits-1:0] count;
    logic push;
    logic pop;

    // full blocks the writer, empty hides the head
    assign in_ready  = (count != fifo_cnt_bits'(fifo_depth));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bounded: assert property (@(posedge clk) disable iff (reset)
        count <= fifo_cnt_bits'(fifo_depth));

endmodule
